// File: chip8_cfg.svh
`ifndef CHIP8_CFG_SVH
`define CHIP8_CFG_SVH

// Datapath widths
`define CHIP8_ADDR_W 12
`define CHIP8_BYTE_W 8
`define CHIP8_REG_W 4

// Program entry point after reset
`define CHIP8_RESET_PC 12'h200

// Return-address stack lives at the bottom of memory
`define CHIP8_STACK_BASE 12'h000

// Flag register index
`define CHIP8_VF 4'd15

`endif

// File: chip8_pkg.sv
`include "chip8_cfg.svh"

package chip8_pkg;

  typedef logic [`CHIP8_ADDR_W-1:0] addr_t;
  typedef logic [`CHIP8_BYTE_W-1:0] byte_t;
  typedef logic [`CHIP8_REG_W-1:0]  reg_idx_t;
  typedef logic [15:0]              instr_t;

  // ------------------------------------------------------------
  // Operation classes out of the decoder
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    op_nop,
    op_ret,
    op_halt,
    op_jp,
    op_call,
    op_se_imm,
    op_sne_imm,
    op_se_reg,
    op_sne_reg,
    op_ld_imm,
    op_add_imm,
    op_alu,
    op_ld_i,
    op_jp_v0,
    op_add_i
  } op_class_t;

  // Encoded as the low nibble of the 8xy group
  typedef enum logic [3:0] {
    alu_mov  = 4'h0,
    alu_or   = 4'h1,
    alu_and  = 4'h2,
    alu_xor  = 4'h3,
    alu_add  = 4'h4,
    alu_sub  = 4'h5,
    alu_shr  = 4'h6,
    alu_subn = 4'h7,
    alu_shl  = 4'hE
  } alu_op_t;

  typedef enum logic [3:0] {
    st_idle,
    st_fetch_hi,
    st_fetch_lo,
    st_load_vx,
    st_load_vy,
    st_exec,
    st_store_vx,
    st_store_vf,
    st_push_hi,
    st_push_lo,
    st_pop_hi,
    st_pop_lo,
    st_halt
  } exec_state_t;

  // ------------------------------------------------------------
  // Bundles passed between blocks
  // ------------------------------------------------------------
  typedef struct packed {
    op_class_t op;
    alu_op_t   alu;
    reg_idx_t  x;
    reg_idx_t  y;
    addr_t     nnn;
    byte_t     nn;
  } decoded_t;

  typedef struct packed {
    logic  rd_en;
    logic  wr_en;
    addr_t rd_addr;
    addr_t wr_addr;
    byte_t wr_data;
  } mem_req_t;

  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    byte_t    data;
  } reg_wb_t;

endpackage

// File: chip8_decode.sv
`timescale 1ns/1ps

module chip8_decode
  import chip8_pkg::*;
(
  input  instr_t   instr,
  output decoded_t dec
);

  logic [3:0] hi_nib;
  logic [3:0] lo_nib;

  assign hi_nib = instr[15:12];
  assign lo_nib = instr[3:0];

  always_comb begin
    dec.x   = instr[11:8];
    dec.y   = instr[7:4];
    dec.nnn = instr[11:0];
    dec.nn  = instr[7:0];
    dec.op  = op_nop;
    dec.alu = alu_mov;

    case (hi_nib)
      4'h0: begin
        if (instr[11:0] == 12'h0EE) dec.op = op_ret;
        else if (instr[11:0] == 12'h0FD) dec.op = op_halt;
      end
      4'h1: dec.op = op_jp;
      4'h2: dec.op = op_call;
      4'h3: dec.op = op_se_imm;
      4'h4: dec.op = op_sne_imm;
      4'h5: if (lo_nib == 4'h0) dec.op = op_se_reg;
      4'h6: dec.op = op_ld_imm;
      4'h7: dec.op = op_add_imm;
      4'h8: begin
        // Only the listed sub-ops are ALU ops, the rest fall to nop
        if (lo_nib <= 4'h7 || lo_nib == 4'hE) begin
          dec.op  = op_alu;
          dec.alu = alu_op_t'(lo_nib);
        end
      end
      4'h9: if (lo_nib == 4'h0) dec.op = op_sne_reg;
      4'hA: dec.op = op_ld_i;
      4'hB: dec.op = op_jp_v0;
      4'hF: if (instr[7:0] == 8'h1E) dec.op = op_add_i;
      default: dec.op = op_nop;
    endcase
  end

endmodule

// File: chip8_alu.sv
`timescale 1ns/1ps
`include "chip8_cfg.svh"

module chip8_alu
  import chip8_pkg::*;
(
  input  alu_op_t op,
  input  byte_t   vx,
  input  byte_t   vy,
  output byte_t   result,
  output logic    flag
);

  logic [`CHIP8_BYTE_W:0] sum;

  // Carry lands in the top bit
  assign sum = {1'b0, vx} + {1'b0, vy};

  always_comb begin
    result = vy;
    flag   = 1'b0;
    case (op)
      alu_mov: result = vy;
      alu_or:  result = vx | vy;
      alu_and: result = vx & vy;
      alu_xor: result = vx ^ vy;
      alu_add: begin
        result = sum[`CHIP8_BYTE_W-1:0];
        flag   = sum[`CHIP8_BYTE_W];
      end
      alu_sub: begin
        result = vx - vy;
        flag   = (vx >= vy);
      end
      alu_subn: begin
        result = vy - vx;
        flag   = (vy >= vx);
      end
      alu_shr: begin
        result = vx >> 1;
        flag   = vx[0];
      end
      alu_shl: begin
        result = vx << 1;
        flag   = vx[`CHIP8_BYTE_W-1];
      end
      default: result = vy;
    endcase
  end

endmodule

// File: chip8_execute.sv
`timescale 1ns/1ps
`include "chip8_cfg.svh"

module chip8_execute
  import chip8_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     step,
  input  decoded_t dec,
  input  byte_t    alu_result,
  input  logic     alu_flag,
  input  byte_t    rd_data,
  input  byte_t    mem_rd_data,
  input  logic     mem_rd_ack,
  output instr_t   instr,
  output mem_req_t mem_req,
  output reg_idx_t rd_idx,
  output alu_op_t  alu_op,
  output byte_t    vx,
  output byte_t    vy,
  output reg_wb_t  wb,
  output logic     busy,
  output logic     halted
);

  exec_state_t state;
  addr_t       pc;
  addr_t       index_reg;
  logic [3:0]  sp;
  logic        step_pending;

  instr_t      ir;
  decoded_t    dec_q;
  byte_t       vx_new;
  logic        flag_q;

  addr_t       ret_addr;
  addr_t       stack_addr;
  logic        writes_vf;

  assign ret_addr   = pc + addr_t'(2);
  assign stack_addr = `CHIP8_STACK_BASE + {7'd0, sp, 1'b0};

  // Flag-producing 8xy ops
  assign writes_vf = (dec_q.op == op_alu) &&
                     (dec_q.alu inside {alu_add, alu_sub, alu_shr, alu_subn, alu_shl});

  assign instr  = ir;
  assign alu_op = dec_q.alu;
  assign busy   = (state != st_idle) && (state != st_halt);
  assign halted = (state == st_halt);

  // ------------------------------------------------------------
  // Memory, register read and writeback requests
  // ------------------------------------------------------------
  always_comb begin
    mem_req = '0;
    rd_idx  = '0;
    wb      = '0;

    case (state)
      st_fetch_hi: begin
        mem_req.rd_en   = !mem_rd_ack;
        mem_req.rd_addr = pc;
      end
      st_fetch_lo: begin
        mem_req.rd_en   = !mem_rd_ack;
        mem_req.rd_addr = pc + addr_t'(1);
      end
      st_load_vx: rd_idx = dec.x;
      // Bnnn needs V0 as its offset
      st_load_vy: rd_idx = (dec_q.op == op_jp_v0) ? '0 : dec_q.y;
      st_store_vx: begin
        wb.en   = 1'b1;
        wb.idx  = dec_q.x;
        wb.data = vx_new;
      end
      st_store_vf: begin
        wb.en   = 1'b1;
        wb.idx  = `CHIP8_VF;
        wb.data = {{(`CHIP8_BYTE_W-1){1'b0}}, flag_q};
      end
      st_push_hi: begin
        mem_req.wr_en   = 1'b1;
        mem_req.wr_addr = stack_addr;
        mem_req.wr_data = {4'd0, ret_addr[11:8]};
      end
      st_push_lo: begin
        mem_req.wr_en   = 1'b1;
        mem_req.wr_addr = stack_addr + addr_t'(1);
        mem_req.wr_data = ret_addr[7:0];
      end
      st_pop_hi: begin
        mem_req.rd_en   = !mem_rd_ack;
        mem_req.rd_addr = stack_addr;
      end
      st_pop_lo: begin
        mem_req.rd_en   = !mem_rd_ack;
        mem_req.rd_addr = stack_addr + addr_t'(1);
      end
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= st_idle;
      pc           <= `CHIP8_RESET_PC;
      index_reg    <= '0;
      sp           <= '0;
      step_pending <= 1'b0;
    end else begin
      step_pending <= step_pending | step;

      case (state)
        st_idle: begin
          if (step_pending) begin
            step_pending <= 1'b0;
            state        <= st_fetch_hi;
          end
        end
        st_fetch_hi: if (mem_rd_ack) state <= st_fetch_lo;
        st_fetch_lo: if (mem_rd_ack) state <= st_load_vx;
        st_load_vx:  state <= st_load_vy;
        st_load_vy:  state <= st_exec;

        st_exec: begin
          pc    <= pc + addr_t'(2);
          state <= st_idle;
          case (dec_q.op)
            op_ret: begin
              sp    <= sp - 4'd1;
              state <= st_pop_hi;
            end
            op_halt:    state <= st_halt;
            op_jp:      pc <= dec_q.nnn;
            // PC stays put so the push can use PC+2
            op_call: begin
              pc    <= pc;
              state <= st_push_hi;
            end
            op_se_imm:  if (vx == dec_q.nn) pc <= pc + addr_t'(4);
            op_sne_imm: if (vx != dec_q.nn) pc <= pc + addr_t'(4);
            op_se_reg:  if (vx == vy) pc <= pc + addr_t'(4);
            op_sne_reg: if (vx != vy) pc <= pc + addr_t'(4);
            op_ld_imm, op_add_imm, op_alu: state <= st_store_vx;
            op_ld_i:    index_reg <= dec_q.nnn;
            op_jp_v0:   pc <= dec_q.nnn + addr_t'(vy);
            op_add_i:   index_reg <= index_reg + addr_t'(vx);
            default: ;
          endcase
        end

        st_store_vx: state <= writes_vf ? st_store_vf : st_idle;
        st_store_vf: state <= st_idle;

        st_push_hi:  state <= st_push_lo;
        st_push_lo: begin
          sp    <= sp + 4'd1;
          pc    <= dec_q.nnn;
          state <= st_idle;
        end

        st_pop_hi: begin
          if (mem_rd_ack) begin
            pc[11:8] <= mem_rd_data[3:0];
            state    <= st_pop_lo;
          end
        end
        st_pop_lo: begin
          if (mem_rd_ack) begin
            pc[7:0] <= mem_rd_data;
            state   <= st_idle;
          end
        end

        // Stays here until reset
        st_halt: state <= st_halt;
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Instruction and operand latches
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      st_fetch_hi: if (mem_rd_ack) ir[15:8] <= mem_rd_data;
      st_fetch_lo: if (mem_rd_ack) ir[7:0] <= mem_rd_data;
      st_load_vx: begin
        vx    <= rd_data;
        dec_q <= dec;
      end
      st_load_vy: vy <= rd_data;
      st_exec: begin
        case (dec_q.op)
          op_ld_imm:  vx_new <= dec_q.nn;
          op_add_imm: vx_new <= vx + dec_q.nn;
          default:    vx_new <= alu_result;
        endcase
        flag_q <= alu_flag;
      end
      default: ;
    endcase
  end

endmodule

// File: chip8_memory.sv
`timescale 1ns/1ps
`include "chip8_cfg.svh"

module chip8_memory (
  input  logic               clk,
  input  chip8_pkg::mem_req_t req,
  input  logic               load_en,
  input  chip8_pkg::addr_t   load_addr,
  input  chip8_pkg::byte_t   load_data,
  output chip8_pkg::byte_t   rd_data,
  output logic               rd_ack
);

  localparam int DEPTH = 1 << `CHIP8_ADDR_W;

  chip8_pkg::byte_t mem [DEPTH];

  // Loader takes the write port over the core
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (req.wr_en) begin
      mem[req.wr_addr] <= req.wr_data;
    end
  end

  // Registered read, ack follows the enable by one cycle
  always_ff @(posedge clk) begin
    if (req.rd_en) begin
      rd_data <= mem[req.rd_addr];
    end
    rd_ack <= req.rd_en;
  end

endmodule

// File: chip8_regfile.sv
`timescale 1ns/1ps
`include "chip8_cfg.svh"

module chip8_regfile
  import chip8_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  reg_wb_t  wb,
  input  reg_idx_t rd_idx,
  output byte_t    rd_data,
  input  reg_idx_t dbg_idx,
  output byte_t    dbg_data
);

  localparam int NUM_REGS = 1 << `CHIP8_REG_W;

  byte_t v [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        v[i] <= '0;
      end
    end else if (wb.en) begin
      v[wb.idx] <= wb.data;
    end
  end

  // Execution and debug reads are independent
  assign rd_data  = v[rd_idx];
  assign dbg_data = v[dbg_idx];

endmodule

// File: chip8_core.sv
`timescale 1ns/1ps

module chip8_core
  import chip8_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     step,
  input  logic     load_en,
  input  addr_t    load_addr,
  input  byte_t    load_data,
  input  reg_idx_t dbg_idx,
  output byte_t    dbg_data,
  output logic     busy,
  output logic     halted
);

  mem_req_t mem_req;
  byte_t    mem_rd_data;
  logic     mem_rd_ack;

  instr_t   instr;
  decoded_t dec;

  reg_idx_t rd_idx;
  byte_t    rd_data;
  reg_wb_t  wb;

  alu_op_t  alu_op;
  byte_t    vx;
  byte_t    vy;
  byte_t    alu_result;
  logic     alu_flag;

  // ------------------------------------------------------------
  // Program and stack memory
  // ------------------------------------------------------------
  chip8_memory u_memory (
    .clk       (clk),
    .req       (mem_req),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_data   (mem_rd_data),
    .rd_ack    (mem_rd_ack)
  );

  chip8_decode u_decode (
    .instr (instr),
    .dec   (dec)
  );

  // ------------------------------------------------------------
  // Control and datapath
  // ------------------------------------------------------------
  chip8_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .dec         (dec),
    .alu_result  (alu_result),
    .alu_flag    (alu_flag),
    .rd_data     (rd_data),
    .mem_rd_data (mem_rd_data),
    .mem_rd_ack  (mem_rd_ack),
    .instr       (instr),
    .mem_req     (mem_req),
    .rd_idx      (rd_idx),
    .alu_op      (alu_op),
    .vx          (vx),
    .vy          (vy),
    .wb          (wb),
    .busy        (busy),
    .halted      (halted)
  );

  chip8_alu u_alu (
    .op     (alu_op),
    .vx     (vx),
    .vy     (vy),
    .result (alu_result),
    .flag   (alu_flag)
  );

  chip8_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb       (wb),
    .rd_idx   (rd_idx),
    .rd_data  (rd_data),
    .dbg_idx  (dbg_idx),
    .dbg_data (dbg_data)
  );

endmodule

// File: chip8_tb.sv
`timescale 1ns/1ps
`include "chip8_cfg.svh"

module chip8_tb
  import chip8_pkg::*;
();

  localparam int NUM_ROWS   = 27;
  localparam int MAX_WORDS  = 8;
  // Program bytes written per row, the tail past the program is random fill
  localparam int LOAD_BYTES = 20;
  // Eight instructions of at most 12 cycles each, plus reset and load overhead
  localparam int CYCLE_LIMIT = NUM_ROWS * (MAX_WORDS * 12 + 32) + 200;

  logic     clk;
  logic     rst_n;
  logic     step;
  logic     load_en;
  addr_t    load_addr;
  byte_t    load_data;
  reg_idx_t dbg_idx;
  byte_t    dbg_data;
  logic     busy;
  logic     halted;

  int cycles;
  int n_rows;

  string            row_name  [NUM_ROWS];
  logic [127:0]     row_words [NUM_ROWS];
  int               row_count [NUM_ROWS];
  reg_idx_t         row_idx   [NUM_ROWS];
  byte_t            row_exp   [NUM_ROWS];

  chip8_core uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .dbg_idx   (dbg_idx),
    .dbg_data  (dbg_data),
    .busy      (busy),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the core did not reach halt within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input byte_t expected, input byte_t actual);
    if (expected !== actual) begin
      $display("** Error: test %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input string name, input int count, input logic [127:0] words,
                         input reg_idx_t idx, input byte_t expected);
    row_name[n_rows]  = name;
    row_count[n_rows] = count;
    row_words[n_rows] = words;
    row_idx[n_rows]   = idx;
    row_exp[n_rows]   = expected;
    n_rows            = n_rows + 1;
  endtask

  // Program bytes first, then random bytes that are never executed
  task automatic load_program(input int r);
    logic [15:0] word;
    logic [31:0] rnd;
    byte_t       data;
    for (int b = 0; b < LOAD_BYTES; b++) begin
      if (b < row_count[r] * 2) begin
        word = row_words[r][127 - 16 * (b / 2) -: 16];
        data = (b % 2 == 0) ? word[15:8] : word[7:0];
      end else begin
        rnd  = $urandom();
        data = rnd[7:0];
      end
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= `CHIP8_RESET_PC + addr_t'(b);
      load_data <= data;
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic run_row(input int r);
    logic busy_seen;
    busy_seen = 1'b0;
    @(posedge clk);
    rst_n <= 1'b0;
    step  <= 1'b0;
    repeat (2) @(posedge clk);
    load_program(r);
    @(posedge clk);
    rst_n <= 1'b1;
    step  <= 1'b1;
    // busy has to show while the program runs
    do begin
      @(negedge clk);
      if (busy) begin
        busy_seen = 1'b1;
      end
    end while (!halted);
    @(posedge clk);
    dbg_idx <= row_idx[r];
    @(negedge clk);
    check_value(row_name[r], row_exp[r], dbg_data);
    check_value({row_name[r], "_halted"}, 8'h01, {7'd0, halted});
    check_value({row_name[r], "_busy_seen"}, 8'h01, {7'd0, busy_seen});
    check_value({row_name[r], "_busy_low"}, 8'h00, {7'd0, busy});
  endtask

  // ------------------------------------------------------------
  // Programs and expected register values
  // ------------------------------------------------------------
  task automatic build_table();
    add_row("imm_add", 3, {16'h61F0, 16'h7125, 16'h00FD, 80'h0}, 4'h1, 8'h15);
    // V1 = 5C, V2 = 3A
    add_row("alu_mov", 4, {16'h615C, 16'h623A, 16'h8120, 16'h00FD, 64'h0}, 4'h1, 8'h3A);
    add_row("alu_or", 4, {16'h615C, 16'h623A, 16'h8121, 16'h00FD, 64'h0}, 4'h1, 8'h7E);
    add_row("alu_and", 4, {16'h615C, 16'h623A, 16'h8122, 16'h00FD, 64'h0}, 4'h1, 8'h18);
    add_row("alu_xor", 4, {16'h615C, 16'h623A, 16'h8123, 16'h00FD, 64'h0}, 4'h1, 8'h66);
    // F0 + 20 wraps with a carry
    add_row("alu_add", 4, {16'h61F0, 16'h6220, 16'h8124, 16'h00FD, 64'h0}, 4'h1, 8'h10);
    add_row("alu_add_carry", 4, {16'h61F0, 16'h6220, 16'h8124, 16'h00FD, 64'h0}, 4'hF, 8'h01);
    add_row("alu_sub", 4, {16'h615C, 16'h623A, 16'h8125, 16'h00FD, 64'h0}, 4'h1, 8'h22);
    add_row("alu_sub_flag", 4, {16'h615C, 16'h623A, 16'h8125, 16'h00FD, 64'h0}, 4'hF, 8'h01);
    add_row("alu_subn", 4, {16'h615C, 16'h623A, 16'h8127, 16'h00FD, 64'h0}, 4'h1, 8'hDE);
    add_row("alu_subn_flag", 4, {16'h615C, 16'h623A, 16'h8127, 16'h00FD, 64'h0}, 4'hF, 8'h00);
    add_row("alu_shr", 3, {16'h615D, 16'h8106, 16'h00FD, 80'h0}, 4'h1, 8'h2E);
    add_row("alu_shr_flag", 3, {16'h615D, 16'h8106, 16'h00FD, 80'h0}, 4'hF, 8'h01);
    add_row("alu_shl", 3, {16'h61C1, 16'h810E, 16'h00FD, 80'h0}, 4'h1, 8'h82);
    add_row("alu_shl_flag", 3, {16'h61C1, 16'h810E, 16'h00FD, 80'h0}, 4'hF, 8'h01);
    // Skips, V2 stays 0 when the load is skipped
    add_row("se_imm", 4, {16'h6105, 16'h3105, 16'h6201, 16'h00FD, 64'h0}, 4'h2, 8'h00);
    add_row("se_imm_taken", 4, {16'h6105, 16'h3106, 16'h6201, 16'h00FD, 64'h0}, 4'h2, 8'h01);
    add_row("sne_imm", 4, {16'h6105, 16'h4106, 16'h6201, 16'h00FD, 64'h0}, 4'h2, 8'h00);
    add_row("se_reg", 5, {16'h6105, 16'h6305, 16'h5130, 16'h6201, 16'h00FD, 48'h0},
            4'h2, 8'h00);
    add_row("sne_reg", 5, {16'h6105, 16'h6306, 16'h9130, 16'h6201, 16'h00FD, 48'h0},
            4'h2, 8'h00);
    add_row("sne_reg_taken", 5, {16'h6105, 16'h6305, 16'h9130, 16'h6201, 16'h00FD, 48'h0},
            4'h2, 8'h01);
    // Jumps over a load into a marker
    add_row("jp", 4, {16'h1204, 16'h6C01, 16'h6D05, 16'h00FD, 64'h0}, 4'hD, 8'h05);
    add_row("jp_over", 4, {16'h1204, 16'h6C01, 16'h6D05, 16'h00FD, 64'h0}, 4'hC, 8'h00);
    add_row("jp_v0", 5, {16'h6002, 16'hB204, 16'h6E01, 16'h6E07, 16'h00FD, 48'h0},
            4'hE, 8'h07);
    // Subroutine at 206 sets VA, the load at 202 runs after the return
    add_row("call_ret", 5, {16'h2206, 16'h6B22, 16'h00FD, 16'h6A11, 16'h00EE, 48'h0},
            4'hB, 8'h22);
    add_row("call_sub", 5, {16'h2206, 16'h6B22, 16'h00FD, 16'h6A11, 16'h00EE, 48'h0},
            4'hA, 8'h11);
    // Load past the halt must not run
    add_row("index_halt", 5, {16'hA123, 16'h6105, 16'hF11E, 16'h00FD, 16'h6401, 48'h0},
            4'h4, 8'h00);
  endtask

  initial begin
    void'($urandom(32'h7644f446));
    rst_n     = 1'b0;
    step      = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    dbg_idx   = '0;
    cycles    = 0;
    n_rows    = 0;

    build_table();
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: all.f
+incdir+.
chip8_pkg.sv
chip8_decode.sv
chip8_alu.sv
chip8_execute.sv
chip8_memory.sv
chip8_regfile.sv
chip8_core.sv
chip8_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module chip8_tb -o chip8_sim \
  && ./obj_dir/chip8_sim \
  || exit 1
